// File: source/busPkg.sv
package busPkg;

  // processor data word
  typedef logic [15:0] wordT;

  // address as seen by the decoder
  typedef struct packed {
    logic [1:0]  region;
    logic [13:0] offset;
  } busFieldsT;

  typedef union packed {
    logic [15:0] raw;  // plain address word
    busFieldsT   f;    // region and offset
  } busAddrU;

  // one request per cycle, no handshake
  typedef struct packed {
    busAddrU addr;
    wordT    wdata;
    logic    we;
  } busReqT;

  // region 0 holds the register window followed by work RAM
  parameter logic [1:0] regionRam = 2'd0;

  // register window size, RAM starts right after it
  parameter int regWindow = 64;

endpackage

// File: source/gamePkg.sv
package gamePkg;

  typedef logic [5:0] regIdxT;

  // register indices used by hardware
  parameter regIdxT frameSync   = 6'd36;
  parameter regIdxT pelletX     = 6'd37;
  parameter regIdxT pelletY     = 6'd38;
  parameter regIdxT pelletClear = 6'd39;
  parameter regIdxT playerRot   = 6'd49;
  parameter regIdxT pelletData  = 6'd51;

  // grid coordinate, 32 cells per axis
  typedef logic [4:0] cellT;

  typedef logic [1:0] dirT;

  parameter dirT dirUp    = 2'd0;
  parameter dirT dirLeft  = 2'd1;
  parameter dirT dirDown  = 2'd2;
  parameter dirT dirRight = 2'd3;

  // cell lookup driven from the register bank
  typedef struct packed {
    cellT x;
    cellT y;
    logic clear;
  } pelletReqT;

  // the four energizer cells sit on these rows and columns
  parameter cellT powerX0 = 5'd2;
  parameter cellT powerX1 = 5'd27;
  parameter cellT powerY0 = 5'd4;
  parameter cellT powerY1 = 5'd24;

endpackage

// File: source/videoTiming.sv
module videoTiming #(
  parameter int hVisible = 640,
  parameter int hFront   = 16,
  parameter int hSync    = 96,
  parameter int hBack    = 48,
  parameter int vVisible = 480,
  parameter int vFront   = 10,
  parameter int vSync    = 2,
  parameter int vBack    = 33
) (
  input  logic clk,
  input  logic rstN,
  output logic hsync,
  output logic vsync,
  output logic frameTick
);

  localparam int hTotal = hVisible + hFront + hSync + hBack;
  localparam int vTotal = vVisible + vFront + vSync + vBack;
  localparam int hBits  = $clog2(hTotal);
  localparam int vBits  = $clog2(vTotal);

  localparam int hSyncStart = hVisible + hFront;
  localparam int vSyncStart = vVisible + vFront;

  logic [hBits-1:0] hpos;
  logic [vBits-1:0] vpos;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      hpos <= '0;
      vpos <= '0;
    end else if (hpos == hBits'(hTotal - 1)) begin
      hpos <= '0;
      vpos <= (vpos == vBits'(vTotal - 1)) ? '0 : vpos + 1'b1;
    end else begin
      hpos <= hpos + 1'b1;
    end
  end

  // both syncs active low
  assign hsync = !(hpos >= hBits'(hSyncStart) && hpos < hBits'(hSyncStart + hSync));
  assign vsync = !(vpos >= vBits'(vSyncStart) && vpos < vBits'(vSyncStart + vSync));

  // first pixel of the blanking interval, once per frame
  assign frameTick = (vpos == vBits'(vVisible)) && (hpos == '0);

endmodule

// File: source/keyDecoder.sv
module keyDecoder (
  input  logic          clk,
  input  logic          rstN,
  input  logic [7:0]    keycode,
  output gamePkg::dirT  dir,
  output logic          keystrobe
);

  logic         hit;
  gamePkg::dirT newDir;
  logic [7:0]   lastCode;

  // arrow codes only, everything else is ignored
  always_comb begin
    hit    = 1'b1;
    newDir = gamePkg::dirUp;
    case (keycode)
      8'hf7:   newDir = gamePkg::dirUp;
      8'hf3:   newDir = gamePkg::dirDown;
      8'he1:   newDir = gamePkg::dirLeft;
      8'he4:   newDir = gamePkg::dirRight;
      default: hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      dir       <= gamePkg::dirLeft;
      keystrobe <= 1'b0;
      lastCode  <= '0;
    end else begin
      lastCode  <= keycode;
      keystrobe <= 1'b0;
      if (hit && keycode != lastCode) begin  // one strobe per new code
        dir       <= newDir;
        keystrobe <= 1'b1;
      end
    end
  end

endmodule

// File: source/gameRegs.sv
module gameRegs (
  input  logic               clk,
  input  logic               rstN,
  input  logic               regWe,
  input  gamePkg::regIdxT    regIdx,
  input  busPkg::wordT       wdata,
  output busPkg::wordT       regRdata,
  input  logic               frameTick,
  input  gamePkg::dirT       dir,
  output gamePkg::pelletReqT pelletReq,
  input  logic [1:0]         pelletBits
);

  localparam int numRegs = 64;

  busPkg::wordT regFile [numRegs];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < numRegs; i++) begin
        regFile[i] <= '0;
      end
    end else begin
      if (regWe) begin
        regFile[regIdx] <= wdata;
      end
      // tick comes last so it beats a same-cycle write of zero
      if (frameTick) begin
        regFile[gamePkg::frameSync] <= 16'd1;
      end
    end
  end

  // live values replace two of the stored words on readback
  always_comb begin
    case (regIdx)
      gamePkg::playerRot:  regRdata = 16'(dir);
      gamePkg::pelletData: regRdata = 16'(pelletBits);
      default:             regRdata = regFile[regIdx];
    endcase
  end

  assign pelletReq.x     = regFile[gamePkg::pelletX][4:0];
  assign pelletReq.y     = regFile[gamePkg::pelletY][4:0];
  assign pelletReq.clear = regFile[gamePkg::pelletClear][0];  // held until cpu writes 0

endmodule

// File: source/pelletStore.sv
module pelletStore (
  input  logic               clk,
  input  logic               rstN,
  input  gamePkg::pelletReqT pelletReq,
  output logic [1:0]         pelletBits
);

  localparam int cellBits = $bits(gamePkg::cellT);
  localparam int numCells = 1 << (2 * cellBits);

  logic [numCells-1:0]   grid;
  logic [2*cellBits-1:0] cellIdx;
  logic                  present;
  logic                  onPower;

  // row major, y selects the row
  assign cellIdx = {pelletReq.y, pelletReq.x};

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      grid <= '1;  // every cell starts with a pellet
    end else if (pelletReq.clear) begin
      grid[cellIdx] <= 1'b0;
    end
  end

  assign present = grid[cellIdx];

  assign onPower = (pelletReq.x == gamePkg::powerX0 || pelletReq.x == gamePkg::powerX1) &&
                   (pelletReq.y == gamePkg::powerY0 || pelletReq.y == gamePkg::powerY1);

  // an eaten energizer reads as empty
  assign pelletBits = {present && onPower, present};

endmodule

// File: source/workRam.sv
module workRam #(
  parameter int ramWords = 16320
) (
  input  logic         clk,
  input  logic         ramWe,
  input  logic [13:0]  ramOffset,
  input  busPkg::wordT wdata,
  output busPkg::wordT ramRdata
);

  busPkg::wordT mem [ramWords];

  logic [13:0] wordIdx;

  // bus offset counts from the register window base
  assign wordIdx = ramOffset - 14'(busPkg::regWindow);

  always_ff @(posedge clk) begin
    if (ramWe) begin
      mem[wordIdx] <= wdata;
    end
  end

  assign ramRdata = mem[wordIdx];  // async read, decoder registers it

endmodule

// File: source/busDecoder.sv
module busDecoder (
  input  logic            clk,
  input  logic            rstN,
  input  busPkg::busReqT  cpuReq,
  output busPkg::wordT    cpuRdata,
  output logic            regWe,
  output gamePkg::regIdxT regIdx,
  output logic            ramWe,
  output logic [13:0]     ramOffset,
  output busPkg::wordT    wdata,
  input  busPkg::wordT    regRdata,
  input  busPkg::wordT    ramRdata
);

  logic inRegion;
  logic regSel;
  logic ramSel;

  assign inRegion = cpuReq.addr.f.region == busPkg::regionRam;
  assign regSel   = inRegion && cpuReq.addr.f.offset < 14'(busPkg::regWindow);
  assign ramSel   = inRegion && !regSel;

  // address fans out unqualified, only the strobes are gated
  assign regIdx    = cpuReq.addr.raw[5:0];
  assign ramOffset = cpuReq.addr.f.offset;
  assign wdata     = cpuReq.wdata;

  assign regWe = cpuReq.we && regSel;
  assign ramWe = cpuReq.we && ramSel;

  // one cycle read latency for every address
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      cpuRdata <= '0;
    end else if (regSel) begin
      cpuRdata <= regRdata;
    end else if (ramSel) begin
      cpuRdata <= ramRdata;
    end else begin
      cpuRdata <= '0;  // unmapped
    end
  end

endmodule

// File: source/gameTop.sv
module gameTop #(
  parameter int hVisible = 640,
  parameter int hFront   = 16,
  parameter int hSync    = 96,
  parameter int hBack    = 48,
  parameter int vVisible = 480,
  parameter int vFront   = 10,
  parameter int vSync    = 2,
  parameter int vBack    = 33,
  parameter int ramWords = 16320
) (
  input  logic           clk,
  input  logic           rstN,
  input  logic [7:0]     keycode,
  output logic           keystrobe,
  input  busPkg::busReqT cpuReq,
  output busPkg::wordT   cpuRdata,
  output logic           hsync,
  output logic           vsync
);

  logic               frameTick;
  gamePkg::dirT       dir;
  logic               regWe;
  gamePkg::regIdxT    regIdx;
  logic               ramWe;
  logic [13:0]        ramOffset;
  busPkg::wordT       wdata;
  busPkg::wordT       regRdata;
  busPkg::wordT       ramRdata;
  gamePkg::pelletReqT pelletReq;
  logic [1:0]         pelletBits;

  videoTiming #(
    .hVisible(hVisible), .hFront(hFront), .hSync(hSync), .hBack(hBack),
    .vVisible(vVisible), .vFront(vFront), .vSync(vSync), .vBack(vBack)
  ) timing (
    .clk(clk), .rstN(rstN), .hsync(hsync), .vsync(vsync), .frameTick(frameTick)
  );

  keyDecoder keys (
    .clk(clk), .rstN(rstN), .keycode(keycode), .dir(dir), .keystrobe(keystrobe)
  );

  busDecoder decoder (
    .clk(clk), .rstN(rstN), .cpuReq(cpuReq), .cpuRdata(cpuRdata),
    .regWe(regWe), .regIdx(regIdx), .ramWe(ramWe), .ramOffset(ramOffset),
    .wdata(wdata), .regRdata(regRdata), .ramRdata(ramRdata)
  );

  gameRegs regs (
    .clk(clk), .rstN(rstN), .regWe(regWe), .regIdx(regIdx), .wdata(wdata),
    .regRdata(regRdata), .frameTick(frameTick), .dir(dir),
    .pelletReq(pelletReq), .pelletBits(pelletBits)
  );

  workRam #(.ramWords(ramWords)) ram (
    .clk(clk), .ramWe(ramWe), .ramOffset(ramOffset), .wdata(wdata), .ramRdata(ramRdata)
  );

  pelletStore pellets (
    .clk(clk), .rstN(rstN), .pelletReq(pelletReq), .pelletBits(pelletBits)
  );

endmodule

// File: bench/gameTopTests.svh
function automatic bit isSpecialReg(input logic [5:0] idx);
  return idx inside {gamePkg::frameSync, gamePkg::pelletX, gamePkg::pelletY,
                     gamePkg::pelletClear, gamePkg::playerRot, gamePkg::pelletData};
endfunction

task automatic resetValues();
  checkEq("reset keystrobe", 16'd0, 16'(keystrobe));
  checkEq("reset hsync", 16'd1, 16'(hsync));
  checkEq("reset vsync", 16'd1, 16'(vsync));
  checkEq("reset cpuRdata", 16'd0, cpuRdata);
endtask

task automatic pressKey(input logic [7:0] code, output int strobes);
  strobes = 0;
  @(posedge clk);
  keycode <= code;
  repeat (4) begin
    @(negedge clk);
    if (keystrobe) strobes++;
  end
  @(posedge clk);
  keycode <= 8'h00;  // release so the next press is a new code
  repeat (2) begin
    @(negedge clk);
    if (keystrobe) strobes++;
  end
endtask

task automatic keyDecoding();
  logic [7:0]  codes [4];
  logic [15:0] dirs [4];
  logic [15:0] rd;
  int          strobes;
  codes = '{8'hf7, 8'hf3, 8'he1, 8'he4};
  dirs  = '{16'd0, 16'd2, 16'd1, 16'd3};
  busRead(16'(gamePkg::playerRot), rd);
  checkEq("keys reset dir", 16'd1, rd);
  for (int i = 0; i < 4; i++) begin
    pressKey(codes[i], strobes);
    checkEq($sformatf("keys %h strobes", codes[i]), 16'd1, 16'(strobes));
    busRead(16'(gamePkg::playerRot), rd);
    checkEq($sformatf("keys %h dir", codes[i]), dirs[i], rd);
  end
  // bit 7 clear, then an unlisted break code
  pressKey(8'h77, strobes);
  checkEq("keys 77 strobes", 16'd0, 16'(strobes));
  pressKey(8'hc5, strobes);
  checkEq("keys c5 strobes", 16'd0, 16'(strobes));
  busRead(16'(gamePkg::playerRot), rd);
  checkEq("keys dir held", 16'd3, rd);
endtask

task automatic selectCell(input logic [4:0] x, input logic [4:0] y);
  busWrite(16'(gamePkg::pelletX), 16'(x));
  busWrite(16'(gamePkg::pelletY), 16'(y));
endtask

task automatic pelletReadback();
  logic [15:0] rd;
  selectCell(5'd5, 5'd5);
  busRead(16'(gamePkg::pelletData), rd);
  checkEq("pellet plain cell", 16'd1, rd);
  selectCell(5'd2, 5'd4);
  busRead(16'(gamePkg::pelletData), rd);
  checkEq("pellet power cell", 16'd3, rd);
  busWrite(16'(gamePkg::pelletClear), 16'd1);
  busWrite(16'(gamePkg::pelletClear), 16'd0);  // clear must drop before moving
  busRead(16'(gamePkg::pelletData), rd);
  checkEq("pellet cleared", 16'd0, rd);
  selectCell(5'd27, 5'd24);
  busRead(16'(gamePkg::pelletData), rd);
  checkEq("pellet other power", 16'd3, rd);
endtask

task automatic regRamAccess();
  logic [5:0]  idx;
  logic [13:0] offset;
  logic [15:0] value;
  logic [15:0] other;
  logic [15:0] rd;
  for (int i = 0; i < 8; i++) begin
    idx = 6'($random(seed));
    while (isSpecialReg(idx)) idx = 6'($random(seed));
    value = 16'($random(seed));
    busWrite({10'd0, idx}, value);
    busRead({10'd0, idx}, rd);
    checkEq($sformatf("reg %0d readback", idx), value, rd);
  end
  for (int i = 0; i < 8; i++) begin
    offset = 14'(busPkg::regWindow) + 14'($unsigned($random(seed)) % ramSpan);
    value  = 16'($random(seed));
    busWrite({2'b00, offset}, value);
    busRead({2'b00, offset}, rd);
    checkEq($sformatf("ram %0d readback", offset), value, rd);
  end
  // second read request goes out while the first is still in flight
  value = 16'($random(seed));
  other = 16'($random(seed));
  busWrite(16'd64, value);
  busWrite(16'd65, other);
  @(posedge clk);
  cpuReq <= makeReq(16'd64, 16'h0000, 1'b0);
  @(posedge clk);
  cpuReq <= makeReq(16'd65, 16'h0000, 1'b0);
  @(negedge clk);
  checkEq("ram pipelined first", value, cpuRdata);
  @(posedge clk);
  cpuReq <= '0;
  @(negedge clk);
  checkEq("ram pipelined second", other, cpuRdata);
  for (int r = 1; r < 4; r++) begin
    offset = 14'($random(seed));
    busWrite({2'(r), offset}, 16'hffff);
    busRead({2'(r), offset}, rd);
    checkEq($sformatf("region %0d read", r), 16'd0, rd);
  end
endtask

task automatic frameSyncFlag();
  logic [15:0] rd;
  waitSyncEdge(1'b1, 1'b1, 2 * frameCycles);  // vsync just ended so the next tick is 9 lines off
  busWrite(16'(gamePkg::frameSync), 16'd0);
  busRead(16'(gamePkg::frameSync), rd);
  checkEq("frame sync cleared", 16'd0, rd);
  waitSyncEdge(1'b1, 1'b0, 2 * frameCycles);
  busRead(16'(gamePkg::frameSync), rd);
  checkEq("frame sync set", 16'd1, rd);
endtask

task automatic measureSync(input bit useV, input int limit, output int lowLen,
                           output int period);
  bit prev;
  bit cur;
  lowLen = 0;
  period = 0;
  waitSyncEdge(useV, 1'b0, limit);
  prev = 1'b0;
  for (int n = 1; n <= limit && period == 0; n++) begin
    @(negedge clk);
    cur = useV ? vsync : hsync;
    if (!prev && cur) lowLen = n;
    if (prev && !cur) period = n;
    prev = cur;
  end
endtask

task automatic syncTiming();
  int lowLen;
  int period;
  measureSync(1'b0, 2 * lineCycles, lowLen, period);
  checkEq("hsync low cycles", 16'd4, 16'(lowLen));
  checkEq("hsync period", 16'(lineCycles), 16'(period));
  measureSync(1'b1, 2 * frameCycles, lowLen, period);
  checkEq("vsync low cycles", 16'd48, 16'(lowLen));
  checkEq("vsync period", 16'(frameCycles), 16'(period));
endtask

// File: bench/gameTopTb.sv
module gameTopTb;

  localparam int ramSpan     = 16320;
  localparam int lineCycles  = 24;   // 16 + 2 + 4 + 2
  localparam int frameCycles = 288;  // 12 lines of 24 cycles

  // the frame and sync tests take a few frames and the rest a few hundred cycles
  localparam int timeoutCycles = 20000;

  logic           clk;
  logic           rstN;
  logic [7:0]     keycode;
  logic           keystrobe;
  busPkg::busReqT cpuReq;
  busPkg::wordT   cpuRdata;
  logic           hsync;
  logic           vsync;

  int     errorCount = 0;
  int     cycleCount = 0;
  integer seed       = 32'h1543_6345;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  gameTop #(
    .hVisible(16), .hFront(2), .hSync(4), .hBack(2),
    .vVisible(8), .vFront(1), .vSync(2), .vBack(1),
    .ramWords(ramSpan)
  ) DUT (
    .clk(clk), .rstN(rstN), .keycode(keycode), .keystrobe(keystrobe),
    .cpuReq(cpuReq), .cpuRdata(cpuRdata), .hsync(hsync), .vsync(vsync)
  );

  initial begin
    while (cycleCount < timeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout after %0d cycles, the tests did not finish", timeoutCycles);
    $display("errors: %0d", errorCount + 1);
    $display("Verification failed");
    $finish;
  end

  task automatic checkEq(input string testName, input logic [15:0] expected,
                         input logic [15:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s expected %h actual %h", testName, expected, actual);
      errorCount++;
    end
  endtask

  function automatic busPkg::busReqT makeReq(input logic [15:0] addr,
                                             input logic [15:0] data, input logic we);
    busPkg::busReqT req;
    req.addr.raw = addr;
    req.wdata    = data;
    req.we       = we;
    return req;
  endfunction

  // write lands on the second rising edge
  task automatic busWrite(input logic [15:0] addr, input logic [15:0] data);
    @(posedge clk);
    cpuReq <= makeReq(addr, data, 1'b1);
    @(posedge clk);
    cpuReq <= '0;
  endtask

  task automatic busRead(input logic [15:0] addr, output logic [15:0] data);
    @(posedge clk);
    cpuReq <= makeReq(addr, 16'h0000, 1'b0);
    @(posedge clk);
    cpuReq <= '0;
    @(negedge clk);
    data = cpuRdata;  // one cycle latency
  endtask

  // sync levels are sampled on falling clock edges only
  task automatic waitSyncEdge(input bit useV, input bit rising, input int limit);
    bit prev;
    bit cur;
    bit seen;
    seen = 1'b0;
    @(negedge clk);
    prev = useV ? vsync : hsync;
    for (int n = 0; n < limit && !seen; n++) begin
      @(negedge clk);
      cur  = useV ? vsync : hsync;
      seen = (prev != rising) && (cur == rising);
      prev = cur;
    end
    if (!seen) begin
      $display("%s %s edge not seen within %0d cycles", useV ? "vsync" : "hsync",
               rising ? "rising" : "falling", limit);
      errorCount++;
    end
  endtask

  `include "gameTopTests.svh"

  initial begin
    rstN    = 1'b0;
    keycode = 8'h00;
    cpuReq  = '0;
    repeat (3) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);

    resetValues();
    keyDecoding();
    pelletReadback();
    regRamAccess();
    frameSyncFlag();
    syncTiming();

    $display("errors: %0d", errorCount);
    if (errorCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: gameTop.f
+incdir+bench
source/busPkg.sv
source/gamePkg.sv
source/videoTiming.sv
source/keyDecoder.sv
source/gameRegs.sv
source/pelletStore.sv
source/workRam.sv
source/busDecoder.sv
source/gameTop.sv
bench/gameTopTb.sv
